// File: verilog/i2c_accel_cfg.svh
`ifndef I2C_ACCEL_CFG_SVH
`define I2C_ACCEL_CFG_SVH

// accelerometer 7-bit address, used in hw_burst
`define I2C_DEV_ADDR 7'h1D

// TEMP2, first of temp + xyz data
`define I2C_BURST_REG 8'h06

`define I2C_BURST_LEN 11

// quarter period 2^(r+2) clocks
`define I2C_DEF_RATE 2'd1

`endif

// File: verilog/i2c_accel_pkg.sv
`include "i2c_accel_cfg.svh"

package i2c_accel_pkg;

	typedef enum logic [1:0] {
		cpu_single = 2'd0,
		cpu_burst  = 2'd1,
		hw_burst   = 2'd2
	} i2c_mode_e;

	typedef struct packed {
		logic       start;    // one cycle pulse
		logic       rd;
		i2c_mode_e  mode;
		logic [1:0] rate;
		logic [6:0] dev_addr;
		logic [7:0] reg_addr;
		logic [7:0] wr_data;
	} i2c_ctrl_t;

	typedef struct packed {
		logic ready;
		logic busy;
		logic done;
		logic nack;     // sticky until next start
	} i2c_status_t;

	typedef struct packed {
		logic scl_low;
		logic sda_low;
	} i2c_pins_t;

	typedef struct packed {
		logic [15:0] temp;
		logic [23:0] x;     // 20-bit sample, 4 reserved lsbs
		logic [23:0] y;
		logic [23:0] z;
	} accel_sample_t;

	// byte 0 is the first byte off the bus, msb of the word
	typedef union packed {
		logic [0:`I2C_BURST_LEN-1][7:0] bytes;
		accel_sample_t                   sample;
	} accel_burst_u;

	typedef enum logic [3:0] {
		ph_idle, ph_start, ph_addr, ph_addr_ack, ph_reg, ph_reg_ack,
		ph_wdata, ph_wdata_ack, ph_rdata, ph_mack, ph_stop
	} i2c_phase_e;

endpackage

// File: verilog/i2c_tick_gen.sv
`timescale 1ns/10ps

module i2c_tick_gen (
	input  logic       i_clk,
	input  logic       i_rst_n,
	input  logic       i_en,
	input  logic [1:0] i_rate,
	output logic       o_tick,
	output logic [1:0] o_phase
);

	logic [4:0] cnt;
	logic [5:0] period;
	logic       term;

	assign period = 6'd4 << i_rate;  // 4, 8, 16, 32 clocks
	assign term   = ({1'b0, cnt} == period - 6'd1);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			cnt     <= '0;
			o_tick  <= 1'b0;
			o_phase <= '0;
		end else if (!i_en) begin
			cnt     <= '0;
			o_tick  <= 1'b0;
			o_phase <= '0;
		end else begin
			cnt    <= term ? 5'd0 : cnt + 5'd1;
			o_tick <= term;
			if (o_tick)
				o_phase <= o_phase + 2'd1;  // phase belongs to the tick just given
		end
	end

	a_tick_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_tick |=> !o_tick)
		else $error("tick high on two consecutive cycles");

endmodule

// File: verilog/i2c_master_fsm.sv
`timescale 1ns/10ps
`include "i2c_accel_cfg.svh"

module i2c_master_fsm (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_go,
	input  i2c_accel_pkg::i2c_ctrl_t i_req,
	input  logic                     i_tick,
	input  logic [1:0]               i_phase,
	input  logic                     i_sda,
	output i2c_accel_pkg::i2c_pins_t o_pins,
	output logic                     o_busy,
	output logic                     o_done,
	output logic                     o_nack,
	output logic                     o_byte_valid,
	output logic [3:0]               o_byte_idx,
	output logic [7:0]               o_byte,
	output logic                     o_commit
);

	i2c_accel_pkg::i2c_phase_e st;
	logic [7:0] sh;        // outgoing byte msb first
	logic [7:0] rx_sh;
	logic [2:0] bit_cnt;
	logic [3:0] byte_idx;
	logic       rd_pass;   // second transaction of a register read
	logic       last;
	logic       sda_drv;
	logic       go_pend;   // accepted go still waiting for its done

	assign last = (i_req.mode == i2c_accel_pkg::cpu_single) ? (byte_idx == 4'd0) :
		(byte_idx == 4'(`I2C_BURST_LEN - 1));

	always_comb begin
		case (st)
			i2c_accel_pkg::ph_addr,
			i2c_accel_pkg::ph_reg,
			i2c_accel_pkg::ph_wdata: sda_drv = ~sh[7];
			i2c_accel_pkg::ph_mack:  sda_drv = ~last;  // nack the final byte
			i2c_accel_pkg::ph_stop:  sda_drv = 1'b1;
			default:                 sda_drv = 1'b0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			st           <= i2c_accel_pkg::ph_idle;
			o_pins       <= '0;
			o_busy       <= 1'b0;
			o_done       <= 1'b0;
			o_nack       <= 1'b0;
			o_byte_valid <= 1'b0;
			sh           <= '0;
			rx_sh        <= '0;
			bit_cnt      <= '0;
			byte_idx     <= '0;
			rd_pass      <= 1'b0;
		end else begin
			o_done       <= 1'b0;
			o_byte_valid <= 1'b0;
			if (st == i2c_accel_pkg::ph_idle) begin
				if (i_go) begin
					st      <= i2c_accel_pkg::ph_start;
					o_busy  <= 1'b1;
					o_nack  <= 1'b0;
					rd_pass <= 1'b0;
				end
			end else if (i_tick) begin
				case (i_phase)
					2'd0: o_pins.sda_low <= sda_drv;  // scl is low here
					2'd1: o_pins.scl_low <= 1'b0;
					2'd2: begin
						rx_sh <= {rx_sh[6:0], i_sda};
						if (st == i2c_accel_pkg::ph_rdata)
							o_byte_valid <= 1'b1;
						if (st == i2c_accel_pkg::ph_start)
							o_pins.sda_low <= 1'b1;  // start condition
						if (st == i2c_accel_pkg::ph_stop)
							o_pins.sda_low <= 1'b0;  // stop condition
					end
					default: begin
						if (st != i2c_accel_pkg::ph_stop)
							o_pins.scl_low <= 1'b1;
						case (st)
							i2c_accel_pkg::ph_start: begin
								sh      <= {i_req.dev_addr, rd_pass};
								bit_cnt <= 3'd7;
								st      <= i2c_accel_pkg::ph_addr;
							end
							i2c_accel_pkg::ph_addr,
							i2c_accel_pkg::ph_reg,
							i2c_accel_pkg::ph_wdata: begin
								sh <= {sh[6:0], 1'b0};
								if (bit_cnt != 3'd0)
									bit_cnt <= bit_cnt - 3'd1;
								else if (st == i2c_accel_pkg::ph_addr)
									st <= i2c_accel_pkg::ph_addr_ack;
								else if (st == i2c_accel_pkg::ph_reg)
									st <= i2c_accel_pkg::ph_reg_ack;
								else
									st <= i2c_accel_pkg::ph_wdata_ack;
							end
							i2c_accel_pkg::ph_addr_ack: begin
								bit_cnt <= 3'd7;
								if (rx_sh[0]) begin
									o_nack <= 1'b1;
									st     <= i2c_accel_pkg::ph_stop;
								end else if (rd_pass) begin
									byte_idx <= '0;
									st       <= i2c_accel_pkg::ph_rdata;
								end else begin
									sh <= i_req.reg_addr;
									st <= i2c_accel_pkg::ph_reg;
								end
							end
							i2c_accel_pkg::ph_reg_ack: begin
								bit_cnt <= 3'd7;
								sh      <= i_req.wr_data;
								if (rx_sh[0])
									o_nack <= 1'b1;
								if (rx_sh[0] || i_req.rd)
									st <= i2c_accel_pkg::ph_stop;
								else
									st <= i2c_accel_pkg::ph_wdata;
							end
							i2c_accel_pkg::ph_wdata_ack: begin
								if (rx_sh[0])
									o_nack <= 1'b1;
								st <= i2c_accel_pkg::ph_stop;
							end
							i2c_accel_pkg::ph_rdata: begin
								if (bit_cnt == 3'd0)
									st <= i2c_accel_pkg::ph_mack;
								else
									bit_cnt <= bit_cnt - 3'd1;
							end
							i2c_accel_pkg::ph_mack: begin
								bit_cnt <= 3'd7;
								if (last) begin
									st <= i2c_accel_pkg::ph_stop;
								end else begin
									byte_idx <= byte_idx + 4'd1;
									st       <= i2c_accel_pkg::ph_rdata;
								end
							end
							i2c_accel_pkg::ph_stop: begin
								if (!o_nack && i_req.rd && !rd_pass) begin
									rd_pass <= 1'b1;  // address is set so read it back
									st      <= i2c_accel_pkg::ph_start;
								end else begin
									o_busy <= 1'b0;
									o_done <= 1'b1;
									st     <= i2c_accel_pkg::ph_idle;
								end
							end
							default: st <= i2c_accel_pkg::ph_idle;
						endcase
					end
				endcase
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			go_pend <= 1'b0;
		else if (i_go && st == i2c_accel_pkg::ph_idle)
			go_pend <= 1'b1;
		else if (o_done)
			go_pend <= 1'b0;
	end

	assign o_byte_idx = byte_idx;
	assign o_byte     = rx_sh;
	assign o_commit   = i_tick && (i_phase == 2'd3) && (st == i2c_accel_pkg::ph_stop) &&
		rd_pass && !o_nack;

	a_sda_phase0: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		$changed(o_pins.sda_low) |-> $past(i_tick) && ($past(i_phase) == 2'd0 ||
			$past(st) == i2c_accel_pkg::ph_start || $past(st) == i2c_accel_pkg::ph_stop))
		else $error("sda moved outside phase 0");

	a_done_once: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_done |-> go_pend)
		else $error("done without an accepted go");

	a_go_after_done: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_go && st == i2c_accel_pkg::ph_idle) |-> !go_pend || o_done)
		else $error("go accepted before the previous done");

endmodule

// File: verilog/i2c_rd_buffer.sv
`timescale 1ns/10ps
`include "i2c_accel_cfg.svh"

module i2c_rd_buffer (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  logic                        i_byte_valid,
	input  logic [3:0]                  i_byte_idx,
	input  logic [7:0]                  i_byte,
	input  logic                        i_commit,
	output i2c_accel_pkg::accel_burst_u o_burst
);

	i2c_accel_pkg::accel_burst_u shadow;  // assembles the readout in flight

	always_ff @(posedge i_clk) begin
		if (i_byte_valid)
			shadow.bytes[i_byte_idx] <= i_byte;
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n)
			o_burst <= '0;
		else if (i_commit)
			o_burst <= shadow;  // whole burst at once
	end

	a_idx_range: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_byte_valid |-> i_byte_idx < 4'(`I2C_BURST_LEN))
		else $error("byte index beyond burst length");

endmodule

// File: verilog/i2c_accel_top.sv
`timescale 1ns/10ps
`include "i2c_accel_cfg.svh"

module i2c_accel_top (
	input  logic                        i_clk,
	input  logic                        i_rst_n,
	input  i2c_accel_pkg::i2c_ctrl_t    i_ctrl,
	input  logic                        i_drdy,
	input  logic                        i_sda,
	output i2c_accel_pkg::i2c_pins_t    o_pins,
	output i2c_accel_pkg::i2c_status_t  o_status,
	output i2c_accel_pkg::accel_burst_u o_burst
);

	i2c_accel_pkg::i2c_ctrl_t req_q;
	i2c_accel_pkg::i2c_ctrl_t req;
	logic [2:0] drdy_sr;   // sync plus edge stage
	logic       go_q;
	logic       trig;
	logic       ready;
	logic       tick;
	logic [1:0] phase;
	logic       busy;
	logic       done;
	logic       nack;
	logic       byte_valid;
	logic [3:0] byte_idx;
	logic [7:0] rx_byte;
	logic       commit;

	assign ready = !busy && !go_q;
	assign trig  = ready && ((i_ctrl.mode == i2c_accel_pkg::hw_burst) ?
		(drdy_sr[1] && !drdy_sr[2]) : i_ctrl.start);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			drdy_sr    <= '0;
			go_q       <= 1'b0;
			req_q      <= '0;
			req_q.rate <= `I2C_DEF_RATE;
		end else begin
			drdy_sr <= {drdy_sr[1:0], i_drdy};
			go_q    <= trig;
			if (trig)
				req_q <= i_ctrl;
		end
	end

	always_comb begin
		req = req_q;
		if (req_q.mode == i2c_accel_pkg::hw_burst) begin
			req.rd       = 1'b1;
			req.dev_addr = `I2C_DEV_ADDR;
			req.reg_addr = `I2C_BURST_REG;
		end
	end

	i2c_tick_gen u_tick (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.i_en    (busy),
		.i_rate  (req.rate),
		.o_tick  (tick),
		.o_phase (phase)
	);

	i2c_master_fsm u_fsm (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_go         (go_q),
		.i_req        (req),
		.i_tick       (tick),
		.i_phase      (phase),
		.i_sda        (i_sda),
		.o_pins       (o_pins),
		.o_busy       (busy),
		.o_done       (done),
		.o_nack       (nack),
		.o_byte_valid (byte_valid),
		.o_byte_idx   (byte_idx),
		.o_byte       (rx_byte),
		.o_commit     (commit)
	);

	i2c_rd_buffer u_buf (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_byte_valid (byte_valid),
		.i_byte_idx   (byte_idx),
		.i_byte       (rx_byte),
		.i_commit     (commit),
		.o_burst      (o_burst)
	);

	assign o_status.ready = ready;
	assign o_status.busy  = busy;
	assign o_status.done  = done;
	assign o_status.nack  = nack;

endmodule

// File: sim/i2c_slave_model.sv
`timescale 1ns/10ps
`include "i2c_accel_cfg.svh"

module i2c_slave_model #(
	parameter logic [6:0] DEV_ADDR = `I2C_DEV_ADDR
) (
	input  logic       i_scl,
	input  logic       i_sda,
	input  logic [6:0] i_nack_addr,
	output logic       o_sda_low
);

	typedef enum {s_idle, s_addr, s_reg, s_wdata, s_rdata} slave_st_e;

	slave_st_e  st;
	logic [7:0] mem [256];
	logic [7:0] ptr;
	logic [7:0] sh;
	logic [7:0] txb;
	logic       rd_req;
	logic       mack_ok;
	logic       scl_q;
	logic       sda_q;
	int         bit_n;   // -1 right after a start

	initial begin
		st        = s_idle;
		o_sda_low = 1'b0;
		ptr       = '0;
		bit_n     = 0;
		rd_req    = 1'b0;
		mack_ok   = 1'b0;
		scl_q     = 1'b1;
		sda_q     = 1'b1;
	end

	always @(i_scl or i_sda) begin
		if (i_sda != sda_q && i_scl && scl_q) begin
			o_sda_low = 1'b0;
			st        = i_sda ? s_idle : s_addr;  // stop : start
			bit_n     = -1;
		end else if (i_scl && !scl_q && st != s_idle) begin
			if (bit_n < 8 && st != s_rdata)
				sh = {sh[6:0], i_sda};
			else if (bit_n == 8 && st == s_rdata)
				mack_ok = !i_sda;
		end else if (!i_scl && scl_q && st != s_idle) begin
			if (bit_n < 7) begin
				bit_n = bit_n + 1;
				if (st == s_rdata)
					o_sda_low = ~txb[7 - bit_n];
			end else if (bit_n == 7) begin
				bit_n     = 8;
				o_sda_low = 1'b1;  // ack
				case (st)
					s_addr: begin
						rd_req = sh[0];
						if (sh[7:1] != DEV_ADDR || sh[7:1] == i_nack_addr) begin
							o_sda_low = 1'b0;
							st        = s_idle;
						end
					end
					s_reg: ptr = sh;
					s_wdata: begin
						mem[ptr] = sh;
						ptr      = ptr + 8'd1;
					end
					default: begin
						o_sda_low = 1'b0;  // master drives its ack
						ptr       = ptr + 8'd1;
					end
				endcase
			end else begin
				bit_n     = 0;
				o_sda_low = 1'b0;
				if (st == s_addr && rd_req || st == s_rdata && mack_ok) begin
					st        = s_rdata;
					txb       = mem[ptr];
					o_sda_low = ~txb[7];
				end else if (st == s_addr)
					st = s_reg;
				else if (st == s_reg)
					st = s_wdata;
				else if (st == s_rdata)
					st = s_idle;
			end
		end
		scl_q = i_scl;
		sda_q = i_sda;
	end

endmodule

// File: sim/i2c_accel_tb.sv
`timescale 1ns/10ps
`include "i2c_accel_cfg.svh"

module i2c_accel_tb;

	localparam int BIT_CLKS   = 128;  // rate 3
	localparam int XFER_BITS  = 29 + 40 + 3 * 130 + 11;
	localparam int MAX_CYCLES = 2 * XFER_BITS * BIT_CLKS + 2000;

	logic                         i_clk;
	logic                         i_rst_n;
	logic                         i_drdy;
	logic                         sda_line;
	logic                         slave_sda_low;
	logic [6:0]                   nack_addr;
	i2c_accel_pkg::i2c_ctrl_t     ctrl;
	i2c_accel_pkg::i2c_ctrl_t     req;
	i2c_accel_pkg::i2c_pins_t     pins;
	i2c_accel_pkg::i2c_status_t   status;
	i2c_accel_pkg::accel_burst_u  burst;
	i2c_accel_pkg::accel_burst_u  exp_burst;
	i2c_accel_pkg::accel_sample_t exp_sample;
	logic [7:0]                   regs [256];
	logic [31:0]                  lfsr;
	logic [15:0]                  exp_temp;
	logic [7:0]                   exp_val;
	logic [7:0]                   reg_seen;
	logic                         exp_nack;
	logic                         chk_reset;
	logic                         chk_done;
	logic                         chk_burst;
	logic                         chk_temp;
	logic                         chk_sample;
	logic                         chk_reg;
	logic                         chk_quiet;
	int                           done_cnt;
	int                           err_cnt;
	int                           cycles = 0;

	assign sda_line = !pins.sda_low && !slave_sda_low;  // pull-up when both release

	i2c_accel_top dut_i (
		.i_clk    (i_clk),
		.i_rst_n  (i_rst_n),
		.i_ctrl   (ctrl),
		.i_drdy   (i_drdy),
		.i_sda    (sda_line),
		.o_pins   (pins),
		.o_status (status),
		.o_burst  (burst)
	);

	i2c_slave_model slave_i (
		.i_scl       (!pins.scl_low),
		.i_sda       (sda_line),
		.i_nack_addr (nack_addr),
		.o_sda_low   (slave_sda_low)
	);

	initial begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	always @(posedge i_clk) begin
		cycles <= cycles + 1;
		if (status.done)
			done_cnt <= done_cnt + 1;
		if (cycles > MAX_CYCLES) begin
			$display("** FAIL **");
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$finish;
		end
	end

	// 32-bit Fibonacci lfsr stepped once per bit
	function automatic logic [7:0] rand_byte();
		logic [7:0] v;
		logic       fb;
		v = '0;
		for (int i = 0; i < 8; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[6:0], fb};
		end
		return v;
	endfunction

	task automatic report_mismatch(input string msg);
		err_cnt++;
		$display("Mismatch at %0t: %s", $time, msg);
	endtask

	a_reset: assert property (@(posedge i_clk) chk_reset |->
		{status.ready, status.busy, status.done, status.nack} == 4'b1000 && pins == '0)
		else report_mismatch("status or pins not idle after reset");
	a_done: assert property (@(posedge i_clk) chk_done |->
		done_cnt == 1 && status.ready && status.nack == exp_nack)
		else report_mismatch("done count, ready or nack wrong after transfer");
	a_burst: assert property (@(posedge i_clk) chk_burst |-> burst == exp_burst)
		else report_mismatch("burst bytes differ from register map");
	a_temp: assert property (@(posedge i_clk) chk_temp |-> burst.sample.temp == exp_temp)
		else report_mismatch("temp field of single read wrong");
	a_sample: assert property (@(posedge i_clk) chk_sample |-> burst.sample == exp_sample)
		else report_mismatch("sample view fields wrong");
	a_reg: assert property (@(posedge i_clk) chk_reg |-> reg_seen == exp_val)
		else report_mismatch("slave register not written");
	a_quiet: assert property (@(posedge i_clk) chk_quiet |-> done_cnt == 1 && !status.busy)
		else report_mismatch("extra transfer after drdy during busy");

	task automatic clear_checks();
		chk_reset  = 1'b0;
		chk_done   = 1'b0;
		chk_burst  = 1'b0;
		chk_temp   = 1'b0;
		chk_sample = 1'b0;
		chk_reg    = 1'b0;
		chk_quiet  = 1'b0;
	endtask

	task automatic run_xfer(input i2c_accel_pkg::i2c_ctrl_t c);
		@(negedge i_clk);
		done_cnt   = 0;
		ctrl       = c;
		ctrl.start = 1'b1;
		@(negedge i_clk);
		ctrl.start = 1'b0;
		while (!status.done)
			@(negedge i_clk);
		@(negedge i_clk);  // counter has seen done
	endtask

	task automatic burst_read(input logic [7:0] r, input logic [1:0] rate);
		req          = '0;
		req.rd       = 1'b1;
		req.mode     = i2c_accel_pkg::cpu_burst;
		req.rate     = rate;
		req.dev_addr = `I2C_DEV_ADDR;
		req.reg_addr = r;
		run_xfer(req);
		for (int i = 0; i < `I2C_BURST_LEN; i++)
			exp_burst.bytes[i] = regs[8'(r + i)];
		chk_burst = 1'b1;
		chk_done  = 1'b1;
		@(negedge i_clk);
		clear_checks();
	endtask

	initial begin
		i_rst_n   = 1'b0;
		i_drdy    = 1'b0;
		ctrl      = '0;
		nack_addr = 7'h7F;
		exp_nack  = 1'b0;
		err_cnt   = 0;
		done_cnt  = 0;
		lfsr      = 32'd97496;
		clear_checks();
		for (int k = 0; k < 256; k++) begin
			regs[k]          = rand_byte();
			slave_i.mem[k]   = regs[k];
		end
		repeat (5) @(negedge i_clk);
		i_rst_n   = 1'b1;
		@(negedge i_clk);
		chk_reset = 1'b1;
		@(negedge i_clk);
		clear_checks();

		req          = '0;
		req.mode     = i2c_accel_pkg::cpu_single;
		req.dev_addr = `I2C_DEV_ADDR;
		req.reg_addr = rand_byte();
		req.wr_data  = rand_byte();
		run_xfer(req);
		regs[req.reg_addr] = req.wr_data;
		reg_seen = slave_i.mem[req.reg_addr];
		exp_val  = req.wr_data;
		chk_reg  = 1'b1;
		chk_done = 1'b1;
		@(negedge i_clk);
		clear_checks();

		burst_read(rand_byte(), 2'd0);
		burst_read(rand_byte(), 2'd3);

		req.mode     = i2c_accel_pkg::cpu_single;
		req.rd       = 1'b1;
		req.reg_addr = rand_byte();
		run_xfer(req);
		exp_temp           = {regs[req.reg_addr], exp_burst.bytes[1]};
		exp_burst.bytes[0] = regs[req.reg_addr];
		chk_burst = 1'b1;
		chk_temp  = 1'b1;
		chk_done  = 1'b1;
		@(negedge i_clk);
		clear_checks();

		// second drdy edge lands while busy
		ctrl.mode     = i2c_accel_pkg::hw_burst;
		ctrl.rate     = 2'd1;
		ctrl.rd       = 1'b0;   // overridden in hw_burst
		ctrl.dev_addr = 7'h00;
		ctrl.reg_addr = 8'h00;
		done_cnt  = 0;
		i_drdy    = 1'b1;
		while (!status.busy)
			@(negedge i_clk);
		repeat (20) @(negedge i_clk);
		i_drdy = 1'b0;
		repeat (20) @(negedge i_clk);
		i_drdy = 1'b1;
		while (!status.done)
			@(negedge i_clk);
		@(negedge i_clk);
		for (int i = 0; i < `I2C_BURST_LEN; i++)
			exp_burst.bytes[i] = regs[8'h06 + i];
		exp_sample.temp = {regs[6], regs[7]};
		exp_sample.x    = {regs[8], regs[9], regs[10]};
		exp_sample.y    = {regs[11], regs[12], regs[13]};
		exp_sample.z    = {regs[14], regs[15], regs[16]};
		chk_burst  = 1'b1;
		chk_sample = 1'b1;
		chk_done   = 1'b1;
		@(negedge i_clk);
		clear_checks();
		i_drdy = 1'b0;
		repeat (40) @(negedge i_clk);
		chk_quiet = 1'b1;
		@(negedge i_clk);
		clear_checks();
		ctrl.mode = i2c_accel_pkg::cpu_single;

		nack_addr    = `I2C_DEV_ADDR;
		req.reg_addr = 8'h10;
		exp_nack     = 1'b1;
		run_xfer(req);
		chk_burst = 1'b1;
		chk_done  = 1'b1;
		@(negedge i_clk);
		clear_checks();

		repeat (5) @(negedge i_clk);
		$display("tests finished, %0d errors", err_cnt);
		if (err_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: i2c_accel.f
+incdir+verilog
verilog/i2c_accel_pkg.sv
verilog/i2c_tick_gen.sv
verilog/i2c_master_fsm.sv
verilog/i2c_rd_buffer.sv
verilog/i2c_accel_top.sv
sim/i2c_slave_model.sv
sim/i2c_accel_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= i2c_accel_tb
FLIST     ?= i2c_accel.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST)) verilog/i2c_accel_cfg.svh
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q '\*\* FAIL \*\*' $(LOG); then exit 1; fi
	@grep -q '\*\* PASS \*\*' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
